/* verification/l1_cache_vectors.txt */
# name  line_address (hex, tag in bits 12..4, set in bits 3..0)  expected_hit (0 or 1)
# Set 3 carries the LRU eviction sequence, the other sets add unrelated traffic
cold_a 0013 0
warm_a 0013 1
cold_b 0023 0
cold_c 0033 0
cold_d 0043 0
warm_b 0023 1
evict_a_by_e 0053 0
evicted_a 0013 0
keep_b 0023 1
keep_d 0043 1
keep_e 0053 1
keep_a 0013 1
evicted_c 0033 0
evicted_b 0023 0
cold_set5 01a5 0
warm_set5 01a5 1
cold_top 1fff 0
warm_top 1fff 1
cold_zero 0000 0
warm_zero 0000 1
cold_set0 0010 0
cold_a_tag0 0003 0
evicted_e 0053 0
keep_c 0033 1
again_set5 01a5 1
again_set0 0010 1

/* src.f */
+incdir+verification
source/l1_cache_pkg.sv
source/l1_sram.sv
source/l1_way.sv
source/l1_request_stage.sv
source/l1_lru.sv
source/l1_response_stage.sv
source/l1_cache.sv
verification/l1_cache_tb.sv

/* verification/l1_cache_tb_checks.svh */
// Needs error_count, test_name, the DUT outputs and clk declared in the module that includes it
`ifndef L1_CACHE_TB_CHECKS_SVH
`define L1_CACHE_TB_CHECKS_SVH

// Single control bit such as hit_o, ready_o or miss_valid_o
task automatic check_flag(input string what, input logic expected, input logic actual);
	if (actual !== expected)
	begin
		$display("error: %s %s expected %0b actual %0b", test_name, what, expected, actual);
		error_count++;
	end
endtask

task automatic check_line(input string what, input l1_cache_pkg::line_t expected,
	input l1_cache_pkg::line_t actual);
	if (actual !== expected)
	begin
		$display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
		error_count++;
	end
endtask

// Refill request address
task automatic check_addr(input string what, input l1_cache_pkg::line_addr_t expected,
	input l1_cache_pkg::line_addr_t actual);
	if (actual !== expected)
	begin
		$display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
		error_count++;
	end
endtask

// Refill request victim way
task automatic check_way(input string what, input l1_cache_pkg::way_t expected,
	input l1_cache_pkg::way_t actual);
	if (actual !== expected)
	begin
		$display("error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
		error_count++;
	end
endtask

task automatic check_count(input string what, input l1_cache_pkg::counter_t expected,
	input l1_cache_pkg::counter_t actual);
	if (actual !== expected)
	begin
		$display("error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
		error_count++;
	end
endtask

// While held off, the request stays up with the same address and way, and the client stalls
task automatic check_miss_held(input l1_cache_pkg::line_addr_t addr, input l1_cache_pkg::way_t way);
	check_flag("miss_valid_o held", 1'b1, miss_valid_o);
	check_addr("miss_addr_o held", addr, miss_addr_o);
	check_way("miss_way_o held", way, miss_way_o);
	check_flag("ready_o during miss", 1'b0, ready_o);
endtask

task automatic check_reset_state();
	int errors_before;
	errors_before = error_count;
	test_name = "reset_state";
	check_flag("ready_o", 1'b1, ready_o);
	check_flag("resp_valid_o", 1'b0, resp_valid_o);
	check_flag("hit_o", 1'b0, hit_o);
	check_flag("miss_valid_o", 1'b0, miss_valid_o);
	check_count("hit_count_o", '0, hit_count_o);
	check_count("miss_count_o", '0, miss_count_o);
	finish_test(errors_before);
endtask

// Counters settle on the edge after the last response
task automatic check_final_counts();
	int errors_before;
	errors_before = error_count;
	test_name = "event_counts";
	@(negedge clk);
	check_count("hit_count_o", l1_cache_pkg::counter_t'(model_hits), hit_count_o);
	check_count("miss_count_o", l1_cache_pkg::counter_t'(model_misses), miss_count_o);
	finish_test(errors_before);
endtask

`endif

/* verification/l1_cache_tb.sv */
// Reads verification/l1_cache_vectors.txt from the project root, and the refill model always fills the way the cache names
`timescale 1ns/1ps

module l1_cache_tb;

	// Longest wait for any handshake, in clock cycles
	localparam int timeout_cycles = 200;
	// Refill lines are the address pattern scrambled with this key
	localparam l1_cache_pkg::line_t fill_key = 64'hc3a5_96f0_0f69_5a3c;

	logic clk;
	logic reset;
	logic access_i;
	l1_cache_pkg::line_addr_t addr_i;
	logic miss_ready_i;
	logic fill_valid_i;
	l1_cache_pkg::line_addr_t fill_addr_i;
	l1_cache_pkg::way_t fill_way_i;
	l1_cache_pkg::line_t fill_data_i;
	logic ready_o;
	logic resp_valid_o;
	logic hit_o;
	l1_cache_pkg::line_t data_o;
	logic miss_valid_o;
	l1_cache_pkg::line_addr_t miss_addr_o;
	l1_cache_pkg::way_t miss_way_o;
	l1_cache_pkg::counter_t hit_count_o;
	l1_cache_pkg::counter_t miss_count_o;

	integer seed = 32797;
	int error_count = 0;
	int test_count = 0;
	int failed_count = 0;
	int model_hits = 0;
	int model_misses = 0;
	int fills_written = 0;
	bit timed_out = 1'b0;
	string test_name = "none";

	// Reference model of the tag store and the LRU ages
	logic model_valid [l1_cache_pkg::num_sets][l1_cache_pkg::num_ways];
	l1_cache_pkg::tag_t model_tag [l1_cache_pkg::num_sets][l1_cache_pkg::num_ways];
	l1_cache_pkg::way_t model_age [l1_cache_pkg::num_sets][l1_cache_pkg::num_ways];

	`include "l1_cache_tb_checks.svh"

	l1_cache l1_cache_i (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.addr_i(addr_i),
		.ready_o(ready_o),
		.resp_valid_o(resp_valid_o),
		.hit_o(hit_o),
		.data_o(data_o),
		.miss_valid_o(miss_valid_o),
		.miss_ready_i(miss_ready_i),
		.miss_addr_o(miss_addr_o),
		.miss_way_o(miss_way_o),
		.fill_valid_i(fill_valid_i),
		.fill_addr_i(fill_addr_i),
		.fill_way_i(fill_way_i),
		.fill_data_i(fill_data_i),
		.hit_count_o(hit_count_o),
		.miss_count_o(miss_count_o));

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Line value that the next level returns for a line address
	function automatic l1_cache_pkg::line_t fill_line(input l1_cache_pkg::line_addr_t addr);
		return {addr[11:0], {4{addr}}} ^ fill_key;
	endfunction

	// Used way becomes newest, only the ways newer than it step back by one
	task automatic model_touch(input l1_cache_pkg::set_t set, input l1_cache_pkg::way_t way);
		l1_cache_pkg::way_t used_age;
		used_age = model_age[set][way];
		for (int w = 0; w < l1_cache_pkg::num_ways; w++)
		begin
			if (model_age[set][w] > used_age)
				model_age[set][w] = model_age[set][w] - 1'b1;
		end
		model_age[set][way] = 2'd3;
	endtask

	// Waits at falling edges until the cache takes accesses again
	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (ready_o !== 1'b1 && !timed_out)
		begin
			if (cycles == timeout_cycles)
			begin
				$display("timeout: ready_o stayed low for %0d cycles in %s", cycles, test_name);
				error_count++;
				timed_out = 1'b1;
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic finish_test(input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("%s: ok", test_name);
		else
		begin
			failed_count++;
			$display("%s: failed", test_name);
		end
	endtask

	// One access from the vector file, checked one cycle after it is taken
	task automatic run_access(input l1_cache_pkg::line_addr_t addr, input logic file_hit);
		l1_cache_pkg::set_t set;
		l1_cache_pkg::tag_t tag;
		l1_cache_pkg::way_t way;
		logic model_hit;
		int errors_before;
		errors_before = error_count;
		set = addr[3:0];
		tag = addr[12:4];
		model_hit = 1'b0;
		way = '0;
		for (int w = 0; w < l1_cache_pkg::num_ways; w++)
		begin
			if (model_valid[set][w] && model_tag[set][w] == tag)
			begin
				model_hit = 1'b1;
				way = l1_cache_pkg::way_t'(w);
			end
		end
		// On a miss the oldest way is the victim
		if (!model_hit)
		begin
			for (int w = 0; w < l1_cache_pkg::num_ways; w++)
			begin
				if (model_age[set][w] == 2'd0)
					way = l1_cache_pkg::way_t'(w);
			end
		end
		check_flag("vector file hit flag", model_hit, file_hit);
		wait_ready();
		if (timed_out)
			return;
		@(posedge clk);
		access_i <= 1'b1;
		addr_i <= addr;
		@(negedge clk);
		if (ready_o !== 1'b1)
		begin
			$display("%s: ready_o fell before the access was taken", test_name);
			error_count++;
		end
		@(posedge clk);
		access_i <= 1'b0;
		// Response cycle
		@(negedge clk);
		check_flag("resp_valid_o", 1'b1, resp_valid_o);
		check_flag("hit_o", model_hit, hit_o);
		check_flag("ready_o", model_hit, ready_o);
		if (model_hit)
		begin
			check_line("data_o", fill_line(addr), data_o);
			model_hits++;
		end
		else
		begin
			check_flag("miss_valid_o", 1'b1, miss_valid_o);
			check_addr("miss_addr_o", addr, miss_addr_o);
			check_way("miss_way_o", way, miss_way_o);
			model_valid[set][way] = 1'b1;
			model_tag[set][way] = tag;
			model_misses++;
			// The access must stall until the refill model has written the line
			wait_ready();
			if (timed_out)
				return;
			if (fills_written != model_misses)
			begin
				$display("%s: ready_o rose before the missed line was refilled", test_name);
				error_count++;
			end
		end
		model_touch(set, way);
		finish_test(errors_before);
	endtask

	task automatic run_vectors();
		int fd;
		int code;
		string line;
		string vec_name;
		l1_cache_pkg::line_addr_t vec_addr;
		int vec_hit;
		fd = $fopen("verification/l1_cache_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("the vector file verification/l1_cache_vectors.txt could not be opened");
			error_count++;
			return;
		end
		while (!$feof(fd) && !timed_out)
		begin
			code = $fgets(line, fd);
			// Blank lines and lines starting with # carry no access
			if (code > 0 && line.len() > 1 && line.getc(0) != "#")
			begin
				if ($sscanf(line, "%s %h %d", vec_name, vec_addr, vec_hit) == 3)
				begin
					test_name = vec_name;
					run_access(vec_addr, vec_hit[0]);
				end
				else
				begin
					$display("the vector line '%s' could not be parsed", line);
					error_count++;
				end
			end
		end
		$fclose(fd);
	endtask

	// Next level model: acknowledge after a random hold, then write the line one cycle later
	initial
	begin : refill_model
		l1_cache_pkg::line_addr_t hold_addr;
		l1_cache_pkg::way_t hold_way;
		int delay;
		forever
		begin
			@(negedge clk);
			if (reset === 1'b0 && miss_valid_o === 1'b1)
			begin
				hold_addr = miss_addr_o;
				hold_way = miss_way_o;
				delay = $unsigned($random(seed)) % 6;
				repeat (delay)
				begin
					@(negedge clk);
					check_miss_held(hold_addr, hold_way);
				end
				@(posedge clk);
				miss_ready_i <= 1'b1;
				@(negedge clk);
				check_miss_held(hold_addr, hold_way);
				// Handshake edge
				@(posedge clk);
				miss_ready_i <= 1'b0;
				fill_valid_i <= 1'b1;
				fill_addr_i <= hold_addr;
				fill_way_i <= hold_way;
				fill_data_i <= fill_line(hold_addr);
				@(negedge clk);
				check_flag("ready_o before fill", 1'b0, ready_o);
				@(posedge clk);
				fill_valid_i <= 1'b0;
				fills_written++;
			end
		end
	end

	initial
	begin
		reset = 1'b1;
		access_i = 1'b0;
		addr_i = '0;
		miss_ready_i = 1'b0;
		fill_valid_i = 1'b0;
		fill_addr_i = '0;
		fill_way_i = '0;
		fill_data_i = '0;
		// Empty model, way 0 oldest in every set
		for (int s = 0; s < l1_cache_pkg::num_sets; s++)
		begin
			for (int w = 0; w < l1_cache_pkg::num_ways; w++)
			begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
				model_age[s][w] = l1_cache_pkg::way_t'(w);
			end
		end
		repeat (16)
			@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_reset_state();
		run_vectors();
		if (!timed_out)
			check_final_counts();
		$display("tests %0d, failed %0d, errors %0d", test_count, failed_count, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* source/l1_cache.sv */
// One lookup cycle per access and one outstanding miss, the next level must refill the way that was named
`timescale 1ns/1ps

module l1_cache
	(input                                     clk,
	input                                      reset,

	// Client port
	input                                      access_i,
	input l1_cache_pkg::line_addr_t            addr_i,
	output logic                               ready_o,
	output logic                               resp_valid_o,
	output logic                               hit_o,
	output l1_cache_pkg::line_t                data_o,

	// Refill request to the next level
	output logic                               miss_valid_o,
	input                                      miss_ready_i,
	output l1_cache_pkg::line_addr_t           miss_addr_o,
	output l1_cache_pkg::way_t                 miss_way_o,

	// Refill write from the next level
	input                                      fill_valid_i,
	input l1_cache_pkg::line_addr_t            fill_addr_i,
	input l1_cache_pkg::way_t                  fill_way_i,
	input l1_cache_pkg::line_t                 fill_data_i,

	// Event counters
	output l1_cache_pkg::counter_t             hit_count_o,
	output l1_cache_pkg::counter_t             miss_count_o);

	logic rd_en;
	l1_cache_pkg::set_t rd_set;
	l1_cache_pkg::tag_t cmp_tag;
	logic [l1_cache_pkg::num_ways - 1:0] wr_en;
	l1_cache_pkg::set_t wr_set;
	l1_cache_pkg::tag_t wr_tag;
	l1_cache_pkg::line_t wr_data;
	logic req_valid_q;
	l1_cache_pkg::line_addr_t req_addr_q;
	logic [l1_cache_pkg::num_ways - 1:0] way_hit;
	l1_cache_pkg::line_t way_data [l1_cache_pkg::num_ways];

	l1_request_stage l1_request_stage_i (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.addr_i(addr_i),
		.ready_i(ready_o),
		.fill_valid_i(fill_valid_i),
		.fill_addr_i(fill_addr_i),
		.fill_way_i(fill_way_i),
		.fill_data_i(fill_data_i),
		.rd_en_o(rd_en),
		.rd_set_o(rd_set),
		.cmp_tag_o(cmp_tag),
		.wr_en_o(wr_en),
		.wr_set_o(wr_set),
		.wr_tag_o(wr_tag),
		.wr_data_o(wr_data),
		.req_valid_o(req_valid_q),
		.req_addr_o(req_addr_q));

	// All ways are read in parallel, and only the way named by a fill is written
	for (genvar w = 0; w < l1_cache_pkg::num_ways; w++)
	begin : gen_way
		l1_way l1_way_i (
			.clk(clk),
			.reset(reset),
			.rd_en_i(rd_en),
			.rd_set_i(rd_set),
			.cmp_tag_i(cmp_tag),
			.wr_en_i(wr_en[w]),
			.wr_set_i(wr_set),
			.wr_tag_i(wr_tag),
			.wr_data_i(wr_data),
			.hit_o(way_hit[w]),
			.data_o(way_data[w]));
	end

	l1_response_stage l1_response_stage_i (
		.clk(clk),
		.reset(reset),
		.req_valid_i(req_valid_q),
		.req_addr_i(req_addr_q),
		.way_hit_i(way_hit),
		.way_data_i(way_data),
		.miss_ready_i(miss_ready_i),
		.fill_valid_i(fill_valid_i),
		.fill_addr_i(fill_addr_i),
		.resp_valid_o(resp_valid_o),
		.hit_o(hit_o),
		.data_o(data_o),
		.ready_o(ready_o),
		.miss_valid_o(miss_valid_o),
		.miss_addr_o(miss_addr_o),
		.miss_way_o(miss_way_o),
		.hit_count_o(hit_count_o),
		.miss_count_o(miss_count_o));

endmodule

/* source/l1_response_stage.sv */
// Only one miss may be outstanding, and the next level must fill the exact line address that was requested
`timescale 1ns/1ps

module l1_response_stage
	(input                                     clk,
	input                                      reset,

	// Latched request from the request stage
	input                                      req_valid_i,
	input l1_cache_pkg::line_addr_t            req_addr_i,

	// Lookup results of every way
	input [l1_cache_pkg::num_ways - 1:0]       way_hit_i,
	input l1_cache_pkg::line_t                 way_data_i [l1_cache_pkg::num_ways],

	// Handshake and fill traffic from the next level
	input                                      miss_ready_i,
	input                                      fill_valid_i,
	input l1_cache_pkg::line_addr_t            fill_addr_i,

	// Client response
	output logic                               resp_valid_o,
	output logic                               hit_o,
	output l1_cache_pkg::line_t                data_o,
	output logic                               ready_o,

	// Refill request
	output logic                               miss_valid_o,
	output l1_cache_pkg::line_addr_t           miss_addr_o,
	output l1_cache_pkg::way_t                 miss_way_o,

	// Event counters
	output l1_cache_pkg::counter_t             hit_count_o,
	output l1_cache_pkg::counter_t             miss_count_o);

	l1_cache_pkg::way_t hit_way;
	l1_cache_pkg::way_t victim_way;
	logic miss_now;
	logic miss_wait_q;
	logic pending_q;
	l1_cache_pkg::line_addr_t miss_addr_q;
	l1_cache_pkg::way_t miss_way_q;
	l1_cache_pkg::counter_t hit_count_q;
	l1_cache_pkg::counter_t miss_count_q;

	// At most one way can hold a given tag, so a plain priority encode is enough
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < l1_cache_pkg::num_ways; w++)
		begin
			if (way_hit_i[w])
				hit_way = l1_cache_pkg::way_t'(w);
		end
	end

	assign resp_valid_o = req_valid_i;
	assign hit_o = req_valid_i && (|way_hit_i);
	assign data_o = way_data_i[hit_way];
	assign miss_now = req_valid_i && !(|way_hit_i);

	// A miss also claims its victim so that a later miss in the set picks another way
	l1_lru lru_i (
		.clk(clk),
		.reset(reset),
		.use_valid_i(req_valid_i),
		.use_set_i(l1_cache_pkg::addr_set(req_addr_i)),
		.use_way_i(hit_o ? hit_way : victim_way),
		.query_set_i(l1_cache_pkg::addr_set(req_addr_i)),
		.victim_way_o(victim_way));

	// The request is raised straight from the lookup and then held from the registers,
	// since the LRU moves on once the victim has been claimed
	assign miss_valid_o = miss_now || miss_wait_q;
	assign miss_addr_o = miss_wait_q ? miss_addr_q : req_addr_i;
	assign miss_way_o = miss_wait_q ? miss_way_q : victim_way;

	// New accesses stall from the miss response until the missed line is written
	assign ready_o = !pending_q && !miss_now;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			miss_wait_q <= 1'b0;
			pending_q <= 1'b0;
			hit_count_q <= '0;
			miss_count_q <= '0;
		end
		else
		begin
			if (miss_now)
			begin
				miss_wait_q <= !miss_ready_i;
				pending_q <= 1'b1;
			end
			else
			begin
				if (miss_wait_q && miss_ready_i)
					miss_wait_q <= 1'b0;
				if (pending_q && fill_valid_i && fill_addr_i == miss_addr_q)
					pending_q <= 1'b0;
			end

			if (hit_o)
				hit_count_q <= hit_count_q + 1'b1;
			if (miss_now)
				miss_count_q <= miss_count_q + 1'b1;
		end
	end

	// The missed address and victim are payload captured with the miss
	always_ff @(posedge clk)
	begin
		if (miss_now)
		begin
			miss_addr_q <= req_addr_i;
			miss_way_q <= victim_way;
		end
	end

	assign hit_count_o = hit_count_q;
	assign miss_count_o = miss_count_q;

	// A line lives in one way only, since fills always follow a miss on that line
	assert property (@(posedge clk) disable iff (reset) req_valid_i |-> $onehot0(way_hit_i));

	// The refill request may not change while the next level holds it off
	assert property (@(posedge clk) disable iff (reset)
		miss_valid_o && !miss_ready_i |=> miss_valid_o && $stable(miss_addr_o)
			&& $stable(miss_way_o));

endmodule

/* source/l1_lru.sv */
// True LRU over four ways, a use on the edge after an access becomes visible to the following query
`timescale 1ns/1ps

module l1_lru
	(input                              clk,
	input                               reset,

	// Way that was just used in a set
	input                               use_valid_i,
	input l1_cache_pkg::set_t           use_set_i,
	input l1_cache_pkg::way_t           use_way_i,

	// Victim lookup for a set
	input l1_cache_pkg::set_t           query_set_i,
	output l1_cache_pkg::way_t          victim_way_o);

	// Ages share the width of a way index, 0 is the oldest and 3 the newest
	localparam l1_cache_pkg::way_t newest = l1_cache_pkg::way_t'(l1_cache_pkg::num_ways - 1);

	l1_cache_pkg::way_t ages_q [l1_cache_pkg::num_sets][l1_cache_pkg::num_ways];

	// The ages in a set are always distinct, so exactly one way carries age zero
	always_comb
	begin
		victim_way_o = '0;
		for (int w = 0; w < l1_cache_pkg::num_ways; w++)
		begin
			if (ages_q[query_set_i][w] == '0)
				victim_way_o = l1_cache_pkg::way_t'(w);
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		l1_cache_pkg::way_t used_age;

		if (reset)
		begin
			// Way 0 starts as the oldest and way 3 as the newest
			for (int s = 0; s < l1_cache_pkg::num_sets; s++)
				for (int w = 0; w < l1_cache_pkg::num_ways; w++)
					ages_q[s][w] <= l1_cache_pkg::way_t'(w);
		end
		else if (use_valid_i)
		begin
			used_age = ages_q[use_set_i][use_way_i];

			// The used way becomes the newest and only the ways newer than it step back
			for (int w = 0; w < l1_cache_pkg::num_ways; w++)
			begin
				if (l1_cache_pkg::way_t'(w) == use_way_i)
					ages_q[use_set_i][w] <= newest;
				else if (ages_q[use_set_i][w] > used_age)
					ages_q[use_set_i][w] <= ages_q[use_set_i][w] - 1'b1;
			end
		end
	end

endmodule

/* source/l1_request_stage.sv */
// Fill writes are decoded combinationally and an access is taken only while ready_i is high
`timescale 1ns/1ps

module l1_request_stage
	(input                                     clk,
	input                                      reset,

	// Client request
	input                                      access_i,
	input l1_cache_pkg::line_addr_t            addr_i,
	input                                      ready_i,

	// Refill write from the next level
	input                                      fill_valid_i,
	input l1_cache_pkg::line_addr_t            fill_addr_i,
	input l1_cache_pkg::way_t                  fill_way_i,
	input l1_cache_pkg::line_t                 fill_data_i,

	// Read side, shared by every way
	output logic                               rd_en_o,
	output l1_cache_pkg::set_t                 rd_set_o,
	output l1_cache_pkg::tag_t                 cmp_tag_o,

	// Write side, one enable per way
	output logic [l1_cache_pkg::num_ways - 1:0] wr_en_o,
	output l1_cache_pkg::set_t                 wr_set_o,
	output l1_cache_pkg::tag_t                 wr_tag_o,
	output l1_cache_pkg::line_t                wr_data_o,

	// Latched request for the response cycle
	output logic                               req_valid_o,
	output l1_cache_pkg::line_addr_t           req_addr_o);

	logic req_valid_q;
	l1_cache_pkg::line_addr_t req_addr_q;

	// The memories are read only for an accepted access
	assign rd_en_o = access_i && ready_i;
	assign rd_set_o = l1_cache_pkg::addr_set(addr_i);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			req_valid_q <= 1'b0;
		else
			req_valid_q <= rd_en_o;
	end

	// The address moves only when an access is taken
	always_ff @(posedge clk)
	begin
		if (rd_en_o)
			req_addr_q <= addr_i;
	end

	assign req_valid_o = req_valid_q;
	assign req_addr_o = req_addr_q;

	// The compare tag lines up with the registered memory output
	assign cmp_tag_o = l1_cache_pkg::addr_tag(req_addr_q);

	// The fill way turns into a one-hot write enable in the same cycle
	always_comb
	begin
		wr_en_o = '0;
		if (fill_valid_i)
			wr_en_o[fill_way_i] = 1'b1;
	end

	assign wr_set_o = l1_cache_pkg::addr_set(fill_addr_i);
	assign wr_tag_o = l1_cache_pkg::addr_tag(fill_addr_i);
	assign wr_data_o = fill_data_i;

	// A fill must name a known way
	assert property (@(posedge clk) disable iff (reset) fill_valid_i |-> !$isunknown(fill_way_i));

	// An accepted access must carry a known address
	assert property (@(posedge clk) disable iff (reset) rd_en_o |-> !$isunknown(addr_i));

endmodule

/* source/l1_way.sv */
// The compare tag must already be registered, aligned with the read that the request stage issued a cycle earlier
`timescale 1ns/1ps

module l1_way
	(input                              clk,
	input                               reset,

	// Lookup, issued on the access edge
	input                               rd_en_i,
	input l1_cache_pkg::set_t           rd_set_i,
	input l1_cache_pkg::tag_t           cmp_tag_i,

	// Refill write into this way
	input                               wr_en_i,
	input l1_cache_pkg::set_t           wr_set_i,
	input l1_cache_pkg::tag_t           wr_tag_i,
	input l1_cache_pkg::line_t          wr_data_i,

	// Lookup result in the response cycle
	output logic                        hit_o,
	output l1_cache_pkg::line_t         data_o);

	l1_cache_pkg::tag_entry_t tag_rd;
	l1_cache_pkg::tag_entry_t tag_wr;
	logic [l1_cache_pkg::num_sets - 1:0] valid_q;
	l1_cache_pkg::set_t rd_set_q;

	// A refill always installs a valid entry
	assign tag_wr.valid = 1'b1;
	assign tag_wr.tag = wr_tag_i;

	l1_sram #(.payload_t(l1_cache_pkg::tag_entry_t)) tag_sram_i (
		.clk(clk),
		.rd_en_i(rd_en_i),
		.rd_addr_i(rd_set_i),
		.rd_data_o(tag_rd),
		.wr_en_i(wr_en_i),
		.wr_addr_i(wr_set_i),
		.wr_data_i(tag_wr));

	l1_sram #(.payload_t(l1_cache_pkg::line_t)) line_sram_i (
		.clk(clk),
		.rd_en_i(rd_en_i),
		.rd_addr_i(rd_set_i),
		.rd_data_o(data_o),
		.wr_en_i(wr_en_i),
		.wr_addr_i(wr_set_i),
		.wr_data_i(wr_data_i));

	// The memory contents are unknown after reset, this vector marks which sets hold real lines
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			valid_q <= '0;
		else if (wr_en_i)
			valid_q[wr_set_i] <= 1'b1;
	end

	// Set of the read in flight, used to pick its valid bit
	always_ff @(posedge clk)
	begin
		if (rd_en_i)
			rd_set_q <= rd_set_i;
	end

	assign hit_o = valid_q[rd_set_q] && tag_rd.valid && tag_rd.tag == cmp_tag_i;

	// A refill from the next level must name a known set
	assert property (@(posedge clk) disable iff (reset) wr_en_i |-> !$isunknown(wr_set_i));

endmodule

/* source/l1_sram.sv */
// Read data is registered and holds its value when no read is requested, a same-address write shows through
`timescale 1ns/1ps

module l1_sram
	#(parameter type payload_t = l1_cache_pkg::line_t)
	(input                              clk,

	// Read port, data appears one cycle after the request
	input                               rd_en_i,
	input l1_cache_pkg::set_t           rd_addr_i,
	output payload_t                    rd_data_o,

	// Write port
	input                               wr_en_i,
	input l1_cache_pkg::set_t           wr_addr_i,
	input payload_t                     wr_data_i);

	// One word per cache set
	localparam int depth = l1_cache_pkg::num_sets;

	payload_t mem [depth];
	payload_t rd_data_q;

	// The array is written on the same edge that launches a read
	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// A read that collides with a write to the same word returns the new value,
	// so a refill is visible to an access taken on the fill edge
	always_ff @(posedge clk)
	begin
		if (rd_en_i)
		begin
			if (wr_en_i && wr_addr_i == rd_addr_i)
				rd_data_q <= wr_data_i;
			else
				rd_data_q <= mem[rd_addr_i];
		end
	end

	assign rd_data_o = rd_data_q;

endmodule

/* source/l1_cache_pkg.sv */
// Geometry is fixed at four ways of sixteen sets with 64-bit lines, and line addresses carry no byte offset
package l1_cache_pkg;

	// Cache geometry
	localparam int num_ways = 4;
	localparam int num_sets = 16;
	localparam int way_width = 2;
	localparam int set_width = 4;

	// A line address is the set in the low bits with the tag above it
	localparam int line_addr_width = 13;
	localparam int tag_width = line_addr_width - set_width;
	localparam int line_width = 64;
	localparam int counter_width = 16;

	typedef logic [line_width - 1:0] line_t;
	typedef logic [line_addr_width - 1:0] line_addr_t;
	typedef logic [set_width - 1:0] set_t;
	typedef logic [tag_width - 1:0] tag_t;
	typedef logic [way_width - 1:0] way_t;

	// Event counters simply wrap around when they overflow
	typedef logic [counter_width - 1:0] counter_t;

	// One tag memory word, with the valid bit above the tag
	typedef struct packed
	{
		logic valid;
		tag_t tag;
	} tag_entry_t;

	// Set index field of a line address
	function automatic set_t addr_set(line_addr_t addr);
		return addr[set_width - 1:0];
	endfunction

	// Tag field of a line address
	function automatic tag_t addr_tag(line_addr_t addr);
		return addr[line_addr_width - 1:set_width];
	endfunction

endpackage
